// ==== rx_ring_66.f ====
rx_ring_pkg.sv
rx_ring_wr_addr.sv
rx_sync_ring.sv
rx_data_ring.sv
rx_gray_crosser.sv
rx_ring_read_mux.sv
rx_ring_66.sv
rx_ring_66_assertions.sv
rx_ring_66_tb.sv

// ==== Makefile ====
TOP = rx_ring_66_tb

.PHONY: sim clean

# Build and run, a $fatal or a failed assertion gives a non-zero exit status
sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rx_ring_66.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== rx_ring_66_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_ring_66_tb import rx_ring_pkg::*; ();

   logic                       rd_clk;
   logic                       wr_clk;
   logic                       reset;
   logic [payload_width+1:0]   data_in;
   logic                       wrena;
   logic                       wrreq;
   logic [addr_bits-1:0]       rd_address;
   logic [line_width-1:0]      data_out;
   logic [page_count_bits-1:0] pages_written;

   // Page model, the newest accepted block of every page and slot
   logic [payload_width+1:0] model [num_pages][slots_per_page];
   integer seed;
   int wr_page;
   int pages_done;
   int cycle_count;
   int timeout_cycles;

   rx_ring_66 i_dut (
      .rd_clk        (rd_clk),
      .wr_clk        (wr_clk),
      .reset         (reset),
      .data_in       (data_in),
      .wrena         (wrena),
      .wrreq         (wrreq),
      .rd_address    (rd_address),
      .data_out      (data_out),
      .pages_written (pages_written)
   );

   // --------------------
   // Clocks
   // --------------------

   initial begin
      rd_clk = 1'b0;
      forever #2 rd_clk = ~rd_clk;
   end

   // Write clock runs slower and unrelated to rd_clk
   initial begin
      wr_clk = 1'b0;
      forever #3 wr_clk = ~wr_clk;
   end

   // --------------------
   // Compare tasks
   // --------------------

   task automatic check_line(input string name, input logic [line_width-1:0] expected,
                             input logic [line_width-1:0] actual);
      if (actual !== expected) begin
         $display("ERROR %s expected %h actual %h", name, expected, actual);
         $display("Simulation failed");
         $fatal(1, "DMA line mismatch");
      end
   endtask

   task automatic check_pages(input string name, input logic [page_count_bits-1:0] expected);
      if (pages_written !== expected) begin
         $display("ERROR %s expected %0d actual %0d", name, expected, pages_written);
         $display("Simulation failed");
         $fatal(1, "page count mismatch");
      end
   endtask

   // --------------------
   // Expected lines
   // --------------------

   // Two payloads per line, even slot in the low half
   function automatic logic [line_width-1:0] data_line(input int pg, input int ln);
      int s;
      s = 2 * (ln - data_first_line);
      return {model[pg][s+1][payload_width+1:2], model[pg][s][payload_width+1:2]};
   endfunction

   // 64 headers per line in ascending fields
   // With mask set it returns ones over the slots that exist
   function automatic logic [line_width-1:0] sync_line(input int pg, input int ln,
                                                       input bit mask);
      logic [line_width-1:0] v;
      int s;
      v = '0;
      for (int i = 0; i < headers_per_line; i++) begin
         s = ln * headers_per_line + i;
         if (s < slots_per_page)
            v[2*i +: 2] = mask ? 2'b11 : model[pg][s][1:0];
      end
      return v;
   endfunction

   function automatic logic [addr_bits-1:0] line_address(input int pg, input int ln);
      rd_addr_u a;
      a.pg.page = page_bits'(pg);
      a.pg.line = line_bits'(ln);
      return a.flat;
   endfunction

   // --------------------
   // Write side
   // --------------------

   // Writes one page of 496 accepted blocks, gated drops wrreq and wrena at random
   task automatic write_page(input bit gated);
      logic [95:0] rnd;
      logic en;
      logic req;
      int slot;
      slot = 0;
      while (slot < slots_per_page) begin
         @(posedge wr_clk);
         rnd = {$random(seed), $random(seed), $random(seed)};
         req = gated ? rnd[95] : 1'b1;
         // wrena low about one cycle in four, wrreq may still be high
         en = gated ? (rnd[94:93] != 2'b00) : 1'b1;
         data_in <= rnd[payload_width+1:0];
         wrena <= en;
         wrreq <= req;
         if (en && req) begin
            model[wr_page][slot] = rnd[payload_width+1:0];
            slot++;
         end
      end
      // Last block is taken on this edge
      @(posedge wr_clk);
      wrena <= 1'b0;
      wrreq <= 1'b0;
      wr_page = (wr_page + 1) % num_pages;
      pages_done++;
      // Settle through the crosser before the count is compared
      repeat (10) @(posedge rd_clk);
      @(negedge rd_clk);
      check_pages("page count", page_count_bits'(pages_done));
   endtask

   // --------------------
   // Read side
   // --------------------

   // Address goes out on one edge, the line is stable half a cycle after the next
   task automatic read_line(input logic [addr_bits-1:0] addr,
                            output logic [line_width-1:0] line);
      @(posedge rd_clk);
      rd_address <= addr;
      @(posedge rd_clk);
      @(negedge rd_clk);
      line = data_out;
   endtask

   // Sync lines 0-7 then data lines 16-255, the hole is skipped
   task automatic read_page(input int pg, input string name);
      logic [line_width-1:0] got;
      for (int ln = 0; ln < sync_lines; ln++) begin
         read_line(line_address(pg, ln), got);
         check_line($sformatf("%s sync page %0d line %0d", name, pg, ln),
                    sync_line(pg, ln, 1'b0), got & sync_line(pg, ln, 1'b1));
      end
      for (int ln = data_first_line; ln < 2**line_bits; ln++) begin
         read_line(line_address(pg, ln), got);
         check_line($sformatf("%s data page %0d line %0d", name, pg, ln),
                    data_line(pg, ln), got);
      end
   endtask

   // --------------------
   // Test sequence
   // --------------------

   initial begin
      seed = 32'h82c962d1;
      reset = 1'b1;
      data_in = '0;
      wrena = 1'b0;
      wrreq = 1'b0;
      rd_address = '0;
      wr_page = 0;
      pages_done = 0;
      repeat (10) @(posedge rd_clk);
      reset <= 1'b0;
      repeat (10) @(posedge rd_clk);
      @(negedge rd_clk);
      check_pages("count before first page", '0);
      // Full rate pages for payload and header readback
      repeat (3) write_page(1'b0);
      for (int p = 0; p < 3; p++) read_page(p, "full rate");
      // Gated page lands in page 3
      write_page(1'b1);
      read_page(3, "gated");
      // Count runs past 63, pages 0-2 get overwritten with the newest data
      repeat (63) write_page(1'b0);
      for (int p = 0; p < 3; p++) read_page(p, "wrapped");
      $display("Simulation completed successfully");
      $finish;
   end

   // --------------------
   // Timeout
   // --------------------

   initial begin
      // 66 full rate pages plus the gated page at four times the cycles, in wr_clk,
      // scaled by 6/4 to rd_clk, then 7 read pages of 248 lines at 2 cycles each,
      // 67 settle waits and reset, all doubled
      timeout_cycles = 2 * ((3 + 63 + 4) * slots_per_page * 3 / 2
                            + 7 * 248 * 2 + 67 * 12 + 20);
      cycle_count = 0;
      forever begin
         @(posedge rd_clk);
         cycle_count++;
         if (cycle_count >= timeout_cycles) begin
            $display("Timeout, the test did not finish within %0d rd_clk cycles", cycle_count);
            $display("Simulation failed");
            $fatal(1, "timeout");
         end
      end
   end

endmodule

`default_nettype wire

// ==== rx_ring_66_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_ring_66_assertions import rx_ring_pkg::*; (
   input wire                       rd_clk,
   input wire                       wr_clk,
   input wire                       reset,
   input wire                       wr_en,
   input wire [page_bits-1:0]       page,
   input wire [slot_bits-1:0]       slot,
   input wire [addr_bits-1:0]       rd_address,
   input wire [line_width-1:0]      data_out,
   input wire [page_count_bits-1:0] pages_written
);

   // One flag per ring page, set once its last slot was written
   logic [num_pages-1:0] page_done;
   rd_addr_u rd_addr;
   logic sync_read;

   assign rd_addr = rd_address;
   assign sync_read = (rd_addr.pg.line < line_bits'(sync_lines)) && page_done[rd_addr.pg.page];

   always_ff @(posedge wr_clk or posedge reset) begin
      if (reset)
         page_done <= '0;
      else if (wr_en && slot == slot_bits'(slots_per_page - 1))
         page_done[page] <= 1'b1;
   end

   // --------------------
   // Properties
   // --------------------

   // Gray crossing allows a step of zero or one, modulo 64
   a_page_step: assert property (@(posedge rd_clk) disable iff (reset)
      page_count_bits'(pages_written - $past(pages_written)) <= page_count_bits'(1))
      else $error("pages_written stepped by more than one");

   a_slot_range: assert property (@(posedge wr_clk) disable iff (reset)
      slot <= slot_bits'(slots_per_page - 1))
      else $error("slot counter past the last slot of a page");

   // Lines 0-6 are full, line 7 only holds slots 448-495 in its low 96 bits
   a_sync_known: assert property (@(posedge rd_clk) disable iff (reset)
      sync_read && rd_addr.pg.line != line_bits'(sync_lines - 1) |=> !$isunknown(data_out))
      else $error("unknown data on a sync line of a completed page");

   a_last_sync_known: assert property (@(posedge rd_clk) disable iff (reset)
      sync_read && rd_addr.pg.line == line_bits'(sync_lines - 1) |=> !$isunknown(data_out[95:0]))
      else $error("unknown data on the last sync line of a completed page");

endmodule

bind rx_ring_66 rx_ring_66_assertions i_assertions (
   .rd_clk        (rd_clk),
   .wr_clk        (wr_clk),
   .reset         (reset),
   .wr_en         (wr_en),
   .page          (page),
   .slot          (slot),
   .rd_address    (rd_address),
   .data_out      (data_out),
   .pages_written (pages_written)
);

`default_nettype wire

// ==== rx_ring_66.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_ring_66 import rx_ring_pkg::*; (
   input  wire                         rd_clk,
   input  wire                         wr_clk,
   input  wire                         reset,
   input  wire [payload_width+1:0]     data_in,
   input  wire                         wrena,
   input  wire                         wrreq,
   input  wire [addr_bits-1:0]         rd_address,
   output logic [line_width-1:0]       data_out,
   output logic [page_count_bits-1:0]  pages_written
);

   logic                       wr_en;
   logic [page_bits-1:0]       page;
   logic [slot_bits-1:0]       slot;
   logic [page_count_bits-1:0] page_count;
   logic [sync_entry_bits-1:0] sync_entry;
   logic [line_width-1:0]      sync_q;
   logic [line_width-1:0]      data_q;

   // Both rings take the block only when it is accepted
   assign wr_en = wrena & wrreq;

   // --------------------
   // Write side
   // --------------------

   rx_ring_wr_addr i_wr_addr (
      .wr_clk     (wr_clk),
      .reset      (reset),
      .wrena      (wrena),
      .wrreq      (wrreq),
      .page       (page),
      .slot       (slot),
      .page_count (page_count)
   );

   // Sync header is bits 1:0 of the block
   rx_sync_ring i_sync_ring (
      .wr_clk   (wr_clk),
      .rd_clk   (rd_clk),
      .wr_en    (wr_en),
      .page     (page),
      .slot     (slot),
      .sync     (data_in[1:0]),
      .rd_entry (sync_entry),
      .q        (sync_q)
   );

   // Payload is the upper 64 bits, read at the flat line index
   rx_data_ring i_data_ring (
      .wr_clk  (wr_clk),
      .rd_clk  (rd_clk),
      .wr_en   (wr_en),
      .page    (page),
      .slot    (slot),
      .payload (data_in[payload_width+1:2]),
      .rd_line (rd_address),
      .q       (data_q)
   );

   // --------------------
   // Read side
   // --------------------

   // Completed pages over to rd_clk for the driver
   rx_gray_crosser #(
      .WIDTH (page_count_bits)
   ) i_page_crosser (
      .in_clk  (wr_clk),
      .out_clk (rd_clk),
      .reset   (reset),
      .count   (page_count),
      .q       (pages_written)
   );

   rx_ring_read_mux i_read_mux (
      .rd_clk     (rd_clk),
      .reset      (reset),
      .rd_address (rd_address),
      .sync_entry (sync_entry),
      .sync_q     (sync_q),
      .data_q     (data_q),
      .data_out   (data_out)
   );

endmodule

`default_nettype wire

// ==== rx_ring_read_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_ring_read_mux import rx_ring_pkg::*; (
   input  wire                        rd_clk,
   input  wire                        reset,
   input  rd_addr_u                   rd_address,
   output logic [sync_entry_bits-1:0] sync_entry,
   input  wire [line_width-1:0]       sync_q,
   input  wire [line_width-1:0]       data_q,
   output logic [line_width-1:0]      data_out
);

   logic data_sel;

   // --------------------
   // Address decode
   // --------------------

   // Page n lines 0 to 7 map to sync entries 8n to 8n+7
   assign sync_entry = {rd_address.pg.page,
                        rd_address.pg.line[$clog2(sync_lines)-1:0]};

   // Select follows the address by one cycle, same as the ring reads
   // High selects the data ring
   always_ff @(posedge rd_clk or posedge reset) begin
      if (reset)
         data_sel <= 1'b0;
      else
         data_sel <= (rd_address.pg.line >= line_bits'(sync_lines));
   end

   // --------------------
   // Output
   // --------------------

   // Lines 8 to 15 come from the data ring, never written
   assign data_out = data_sel ? data_q : sync_q;

endmodule

`default_nettype wire

// ==== rx_gray_crosser.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_gray_crosser #(
   parameter int WIDTH = 4
) (
   input  wire              in_clk,
   input  wire              out_clk,
   input  wire              reset,
   input  wire [WIDTH-1:0]  count,
   output logic [WIDTH-1:0] q
);

   logic [WIDTH-1:0] gray;
   logic [WIDTH-1:0] sync_1;
   logic [WIDTH-1:0] sync_2;

   // Each bit is the xor of itself and every bit above it
   function automatic logic [WIDTH-1:0] gray_to_bin(input logic [WIDTH-1:0] g);
      logic [WIDTH-1:0] b;
      b[WIDTH-1] = g[WIDTH-1];
      for (int i = WIDTH - 2; i >= 0; i--) begin
         b[i] = b[i+1] ^ g[i];
      end
      return b;
   endfunction

   // --------------------
   // Source domain
   // --------------------

   // Registered so only one bit toggles per count step
   always_ff @(posedge in_clk or posedge reset) begin
      if (reset)
         gray <= '0;
      else
         gray <= count ^ (count >> 1);
   end

   // --------------------
   // Destination domain
   // --------------------

   // Two flops against metastability, then back to binary
   // q never jumps by more than one since gray changes a bit at a time
   always_ff @(posedge out_clk or posedge reset) begin
      if (reset) begin
         sync_1 <= '0;
         sync_2 <= '0;
         q <= '0;
      end else begin
         sync_1 <= gray;
         sync_2 <= sync_1;
         q <= gray_to_bin(sync_2);
      end
   end

endmodule

`default_nettype wire

// ==== rx_data_ring.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_data_ring import rx_ring_pkg::*; (
   input  wire                      wr_clk,
   input  wire                      rd_clk,
   input  wire                      wr_en,
   input  wire [page_bits-1:0]      page,
   input  wire [slot_bits-1:0]      slot,
   input  wire [payload_width-1:0]  payload,
   input  wire [addr_bits-1:0]      rd_line,
   output logic [line_width-1:0]    q
);

   // 256 lines per page, 32 pages
   logic [line_width-1:0] mem [num_pages * (2**line_bits)];

   logic [addr_bits-1:0] wr_line;

   // --------------------
   // Write side
   // --------------------

   // page*256 + 16 + slot/2, in 13 bits
   // The last 16 payload words run past the page end into the low lines
   // of the next page, which the read mux covers with the sync ring
   assign wr_line = {page, {line_bits{1'b0}}}
                  + addr_bits'(data_first_line)
                  + addr_bits'(slot[slot_bits-1:1]);

   // Even slot fills the low half, odd slot the high half
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         if (slot[0])
            mem[wr_line][line_width-1:payload_width] <= payload;
         else
            mem[wr_line][payload_width-1:0] <= payload;
      end
   end

   // --------------------
   // Read side
   // --------------------

   always_ff @(posedge rd_clk) begin
      q <= mem[rd_line];
   end

endmodule

`default_nettype wire

// ==== rx_sync_ring.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_sync_ring import rx_ring_pkg::*; (
   input  wire                        wr_clk,
   input  wire                        rd_clk,
   input  wire                        wr_en,
   input  wire [page_bits-1:0]        page,
   input  wire [slot_bits-1:0]        slot,
   input  wire [1:0]                  sync,
   input  wire [sync_entry_bits-1:0]  rd_entry,
   output logic [line_width-1:0]      q
);

   // 8 lines per page, 32 pages
   logic [line_width-1:0] mem [num_pages*sync_lines];

   logic [sync_entry_bits-1:0] wr_entry;
   logic [$clog2(line_width)-1:0] wr_bit;

   // --------------------
   // Write side
   // --------------------

   // Line within the sync area is slot / 64
   assign wr_entry = {page, slot[slot_bits-1 -: $clog2(sync_lines)]};

   // Field position is 2 * (slot mod 64), ascending from bit 0
   assign wr_bit = {slot[$clog2(headers_per_line)-1:0], 1'b0};

   // Masked write of one 2-bit field, the rest of the line holds
   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wr_entry][wr_bit +: 2] <= sync;
      end
   end

   // --------------------
   // Read side
   // --------------------

   // One cycle read latency on rd_clk
   always_ff @(posedge rd_clk) begin
      q <= mem[rd_entry];
   end

endmodule

`default_nettype wire

// ==== rx_ring_wr_addr.sv ====
`timescale 1ns/100ps
`default_nettype none

module rx_ring_wr_addr import rx_ring_pkg::*; (
   input  wire                        wr_clk,
   input  wire                        reset,
   input  wire                        wrena,
   input  wire                        wrreq,
   output logic [page_bits-1:0]       page,
   output logic [slot_bits-1:0]       slot,
   output logic [page_count_bits-1:0] page_count
);

   logic accept;
   logic last_slot;

   // A block counts only when both the enable and the request are high
   assign accept = wrena & wrreq;
   assign last_slot = (slot == slot_bits'(slots_per_page - 1));

   // --------------------
   // Slot and page counters
   // --------------------

   // page and slot describe the block being accepted on this edge,
   // they move on to the next block at the same edge
   always_ff @(posedge wr_clk or posedge reset) begin
      if (reset) begin
         page <= '0;
         slot <= '0;
         page_count <= '0;
      end else if (accept) begin
         if (last_slot) begin
            // Page done, wrap slot and step to next page
            slot <= '0;
            // Wraps modulo 32 by width
            page <= page + 1'b1;
            // Completed pages, wraps modulo 64
            page_count <= page_count + 1'b1;
         end else begin
            slot <= slot + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rx_ring_pkg.sv ====
`default_nettype none

package rx_ring_pkg;

   // --------------------
   // Ring geometry
   // --------------------

   // Pages held by the ring before it wraps
   localparam int num_pages = 32;
   // 66-bit blocks stored per 4 KB page
   localparam int slots_per_page = 496;
   // Sync header lines at the top of each page
   localparam int sync_lines = 8;
   // First payload line, lines 8 to 15 are a hole
   localparam int data_first_line = 16;

   // DMA line and block payload widths
   localparam int line_width = 128;
   localparam int payload_width = 64;

   // Counter widths
   localparam int page_bits = 5;
   localparam int slot_bits = 9;
   // One extra bit so the driver can tell a full lap from an empty ring
   localparam int page_count_bits = 6;

   // Derived address widths
   // 256 lines of 128 bits per page
   localparam int line_bits = 8;
   localparam int addr_bits = page_bits + line_bits;
   // Sync ring entry, page plus line within the sync area
   localparam int sync_entry_bits = page_bits + $clog2(sync_lines);
   // 2-bit headers packed into one line
   localparam int headers_per_line = line_width / 2;

   // --------------------
   // DMA line address
   // --------------------

   // Same 13 bits, read either as a flat data ring index
   // or split into page and line within the page
   typedef union packed {
      logic [addr_bits-1:0] flat;
      struct packed {
         logic [page_bits-1:0] page;
         logic [line_bits-1:0] line;
      } pg;
   } rd_addr_u;

endpackage

`default_nettype wire
